/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module stack_core_tb \
		-f flist.f -Mdir obj_dir -o stack_core_tb

run: compile
	./obj_dir/stack_core_tb

clean:
	rm -rf obj_dir

/* design/bd_packer.sv */
module bd_packer (
	input  logic                          osc,
	input  logic                          rst_n,
	input  stack_pkg::flit_u              pk_flit,
	input  logic                          pk_valid,
	input  logic                          bd_out_ready,
	output logic                          pk_ready,
	output logic [stack_pkg::BD_OUT_W-1:0] bd_out_data,
	output logic                          bd_out_valid
);

	logic [stack_pkg::PAY_W-1:0] hi_q;  // first flit of a pair
	logic have_hi;
	logic take;
	logic [stack_pkg::BD_OUT_W-1:0] word_nxt;

	// any flit may finish a word, so the word register must be free
	assign pk_ready = !bd_out_valid || bd_out_ready;
	assign take = pk_valid && pk_ready;

	always_comb begin
		word_nxt = '0;
		word_nxt[stack_pkg::BD_LAST_BIT] = pk_flit.pay.tail;
		if (have_hi) begin
			word_nxt[stack_pkg::PAY_W +: stack_pkg::PAY_W] = hi_q;
			word_nxt[0 +: stack_pkg::PAY_W] = pk_flit.pay.data;
		end else begin
			word_nxt[stack_pkg::PAY_W +: stack_pkg::PAY_W] = pk_flit.pay.data;  // low half stays 0
		end
	end

	always_ff @(posedge osc) begin
		if (take) begin
			if (!have_hi)
				hi_q <= pk_flit.pay.data;
			if (have_hi || pk_flit.pay.tail)
				bd_out_data <= word_nxt;
		end
	end

	always_ff @(posedge osc or negedge rst_n) begin
		if (!rst_n) begin
			have_hi <= 1'b0;
			bd_out_valid <= 1'b0;
		end else begin
			if (bd_out_valid && bd_out_ready)
				bd_out_valid <= 1'b0;  // word taken by the chip
			if (take) begin
				if (have_hi || pk_flit.pay.tail)
					bd_out_valid <= 1'b1;  // pair done, or odd tail
				have_hi <= !have_hi && !pk_flit.pay.tail;
			end
		end
	end

endmodule

/* design/bd_unpacker.sv */
module bd_unpacker (
	input  logic                         osc,
	input  logic                         rst_n,
	input  logic [stack_pkg::BD_IN_W-1:0] bd_in_data,
	input  logic                         bd_in_valid,
	input  logic                         bd_pop,
	output logic                         bd_in_ready,
	output stack_pkg::flit_u             bd_flit,
	output logic                         bd_flit_valid,
	output logic                         bd_dir
);

	logic [stack_pkg::BD_IN_W-1:0] word_q;  // held chip word
	logic busy;
	logic [1:0] phase;  // header, high half, low half

	assign bd_in_ready = !busy;  // one word at a time
	assign bd_flit_valid = busy;
	assign bd_dir = word_q[stack_pkg::BD_DIR_BIT];

	always_comb begin
		bd_flit = '0;
		case (phase)
			2'd0: begin
				bd_flit.hdr.hop = word_q[stack_pkg::BD_HOP_LSB +: stack_pkg::HOP_W];
				bd_flit.hdr.tag = word_q[stack_pkg::BD_TAG_LSB +: stack_pkg::TAG_W];
			end
			2'd1: bd_flit.pay.data = word_q[stack_pkg::PAY_W +: stack_pkg::PAY_W];
			default: begin
				bd_flit.pay.tail = 1'b1;  // low half closes the packet
				bd_flit.pay.data = word_q[0 +: stack_pkg::PAY_W];
			end
		endcase
	end

	always_ff @(posedge osc) begin
		if (bd_in_valid && bd_in_ready)
			word_q <= bd_in_data;
	end

	always_ff @(posedge osc or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			phase <= 2'd0;
		end else if (bd_in_valid && bd_in_ready) begin
			busy <= 1'b1;
			phase <= 2'd0;
		end else if (bd_pop) begin
			if (phase == 2'd2) begin
				busy <= 1'b0;  // all three flits gone
				phase <= 2'd0;
			end else begin
				phase <= phase + 2'd1;
			end
		end
	end

endmodule

/* design/flit_switch.sv */
module flit_switch (
	input  logic             osc,
	input  logic             rst_n,
	input  stack_pkg::flit_u bot_head,
	input  stack_pkg::flit_u top_head,
	input  stack_pkg::flit_u bd_flit,
	input  logic [1:0]       top_sel,
	input  logic [1:0]       bot_sel,
	input  logic [1:0]       pk_sel,
	input  logic [2:0]       move,
	input  logic             top_out_ready,
	input  logic             bot_out_ready,
	input  logic             pk_ready,
	output stack_pkg::flit_u top_out,
	output logic             top_out_valid,
	output stack_pkg::flit_u bot_out,
	output logic             bot_out_valid,
	output stack_pkg::flit_u pk_flit,
	output logic             pk_valid,
	output logic [2:0]       dest_free
);

	stack_pkg::flit_u out_q [stack_pkg::NUM_PORTS];  // output registers
	stack_pkg::flit_u nxt [stack_pkg::NUM_PORTS];
	logic [1:0] sel [stack_pkg::NUM_PORTS];
	logic [2:0] out_v;
	logic [2:0] out_rdy;
	logic [2:0] hdr_next;  // next flit on this output opens a packet

	always_comb begin
		sel[stack_pkg::DST_TOP] = top_sel;
		sel[stack_pkg::DST_BOT] = bot_sel;
		sel[stack_pkg::DST_PK] = pk_sel;
		out_rdy[stack_pkg::DST_TOP] = top_out_ready;
		out_rdy[stack_pkg::DST_BOT] = bot_out_ready;
		out_rdy[stack_pkg::DST_PK] = pk_ready;
		for (int d = 0; d < stack_pkg::NUM_PORTS; d++) begin
			case (sel[d])
				stack_pkg::SRC_BOT: nxt[d] = bot_head;
				stack_pkg::SRC_TOP: nxt[d] = top_head;
				default: nxt[d] = bd_flit;
			endcase
			// one board crossed, only for link to link headers
			if (hdr_next[d] && d != stack_pkg::DST_PK && sel[d] != stack_pkg::SRC_BD)
				nxt[d].hdr.hop = nxt[d].hdr.hop - 1'b1;
		end
	end

	assign dest_free = ~out_v | out_rdy;  // empty, or emptied this cycle

	always_ff @(posedge osc) begin
		for (int d = 0; d < stack_pkg::NUM_PORTS; d++)
			if (move[d])
				out_q[d] <= nxt[d];
	end

	always_ff @(posedge osc or negedge rst_n) begin
		if (!rst_n) begin
			out_v <= '0;
			hdr_next <= '1;  // first flit after reset is a header
		end else begin
			for (int d = 0; d < stack_pkg::NUM_PORTS; d++) begin
				if (move[d]) begin
					out_v[d] <= 1'b1;
					hdr_next[d] <= nxt[d].hdr.tail;
				end else if (out_rdy[d]) begin
					out_v[d] <= 1'b0;
				end
			end
		end
	end

	assign top_out = out_q[stack_pkg::DST_TOP];
	assign top_out_valid = out_v[stack_pkg::DST_TOP];
	assign bot_out = out_q[stack_pkg::DST_BOT];
	assign bot_out_valid = out_v[stack_pkg::DST_BOT];
	assign pk_flit = out_q[stack_pkg::DST_PK];
	assign pk_valid = out_v[stack_pkg::DST_PK];

endmodule

/* design/link_fifo.sv */
module link_fifo #(
	parameter int depth = stack_pkg::FIFO_DEPTH  // power of two
) (
	input  logic             osc,
	input  logic             rst_n,
	input  stack_pkg::flit_u in,
	input  logic             in_valid,
	input  logic             pop,        // from route_ctrl, only with head_valid
	output logic             in_ready,
	output stack_pkg::flit_u head,
	output logic             head_valid
);

	localparam int PW = $clog2(depth) + 1;  // pointer plus wrap bit

	stack_pkg::flit_u mem [depth];  // flit storage
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW-1:0] fill;  // entries held
	logic wr_en;

	assign fill = wr_ptr - rd_ptr;
	assign in_ready = fill != PW'(depth);  // low only when full
	assign head_valid = fill != '0;
	assign wr_en = in_valid && in_ready;

	// head falls straight out of storage
	assign head = mem[rd_ptr % depth];

	always_ff @(posedge osc) begin
		if (wr_en)
			mem[wr_ptr % depth] <= in;  // seen at head next cycle
	end

	always_ff @(posedge osc or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;  // wraps with the extra bit
		end
	end

endmodule

/* design/route_ctrl.sv */
module route_ctrl (
	input  logic             osc,
	input  logic             rst_n,
	input  stack_pkg::flit_u bot_head,
	input  logic             bot_head_valid,
	input  stack_pkg::flit_u top_head,
	input  logic             top_head_valid,
	input  stack_pkg::flit_u bd_flit,
	input  logic             bd_flit_valid,
	input  logic             bd_dir,        // chip packet direction, 1 is down
	input  logic [2:0]       dest_free,     // output register can take a flit
	output logic             bot_pop,
	output logic             top_pop,
	output logic             bd_pop,
	output logic [1:0]       top_sel,
	output logic [1:0]       bot_sel,
	output logic [1:0]       pk_sel,
	output logic [2:0]       move
);

	stack_pkg::flit_u src_flit [stack_pkg::NUM_PORTS];
	logic [2:0] src_valid;
	logic [1:0] hdr_dst [stack_pkg::NUM_PORTS];  // destination read from a header
	logic [2:0] src_busy;  // source is mid packet
	logic [1:0] src_route [stack_pkg::NUM_PORTS];  // locked destination per source
	logic [2:0] dst_lock;  // some source owns this output
	logic [1:0] dst_owner [stack_pkg::NUM_PORTS];
	logic [1:0] rr_last [stack_pkg::NUM_PORTS];  // last header winner per output
	logic [2:0] cand [stack_pkg::NUM_PORTS];  // headers asking for each output
	logic [1:0] sel [stack_pkg::NUM_PORTS];
	logic [2:0] pop;

	// next requester after last, wrapping over the three sources
	function automatic logic [1:0] rr_pick(input logic [2:0] req, input logic [1:0] last);
		logic [1:0] pick;
		logic [1:0] idx;
		pick = last;
		for (int k = stack_pkg::NUM_PORTS; k >= 1; k--) begin
			idx = 2'((int'(last) + k) % stack_pkg::NUM_PORTS);
			if (req[idx])
				pick = idx;  // closest one wins, k = 1 last
		end
		return pick;
	endfunction

	always_comb begin
		src_flit[stack_pkg::SRC_BOT] = bot_head;
		src_flit[stack_pkg::SRC_TOP] = top_head;
		src_flit[stack_pkg::SRC_BD] = bd_flit;
		src_valid[stack_pkg::SRC_BOT] = bot_head_valid;
		src_valid[stack_pkg::SRC_TOP] = top_head_valid;
		src_valid[stack_pkg::SRC_BD] = bd_flit_valid;

		// hop zero stops here, anything else keeps climbing or falling
		hdr_dst[stack_pkg::SRC_BOT] = (bot_head.hdr.hop == '0) ? 2'(stack_pkg::DST_PK)
			: 2'(stack_pkg::DST_TOP);
		hdr_dst[stack_pkg::SRC_TOP] = (top_head.hdr.hop == '0) ? 2'(stack_pkg::DST_PK)
			: 2'(stack_pkg::DST_BOT);
		hdr_dst[stack_pkg::SRC_BD] = bd_dir ? 2'(stack_pkg::DST_BOT) : 2'(stack_pkg::DST_TOP);

		// output side view of the per source locks
		dst_lock = '0;
		for (int d = 0; d < stack_pkg::NUM_PORTS; d++)
			dst_owner[d] = stack_pkg::SRC_BOT;
		for (int s = 0; s < stack_pkg::NUM_PORTS; s++) begin
			for (int d = 0; d < stack_pkg::NUM_PORTS; d++) begin
				if (src_busy[s] && src_route[s] == 2'(d)) begin
					dst_lock[d] = 1'b1;
					dst_owner[d] = 2'(s);
				end
			end
		end

		pop = '0;
		for (int d = 0; d < stack_pkg::NUM_PORTS; d++) begin
			for (int s = 0; s < stack_pkg::NUM_PORTS; s++)
				cand[d][s] = src_valid[s] && !src_busy[s] && hdr_dst[s] == 2'(d);
			sel[d] = dst_lock[d] ? dst_owner[d] : rr_pick(cand[d], rr_last[d]);
			// locked output only serves its owner, a free one takes a header
			move[d] = dest_free[d] && (dst_lock[d] ? src_valid[dst_owner[d]] : |cand[d]);
			if (move[d])
				pop[sel[d]] = 1'b1;
		end
	end

	always_ff @(posedge osc or negedge rst_n) begin
		if (!rst_n) begin
			src_busy <= '0;
			for (int i = 0; i < stack_pkg::NUM_PORTS; i++) begin
				src_route[i] <= 2'(stack_pkg::DST_TOP);
				rr_last[i] <= stack_pkg::SRC_BD;  // bot gets first pick
			end
		end else begin
			for (int d = 0; d < stack_pkg::NUM_PORTS; d++) begin
				if (move[d]) begin
					if (!dst_lock[d])
						rr_last[d] <= sel[d];  // pointer moves only at a header
					src_busy[sel[d]] <= !src_flit[sel[d]].hdr.tail;  // tail frees the route
					src_route[sel[d]] <= 2'(d);
				end
			end
		end
	end

	assign top_sel = sel[stack_pkg::DST_TOP];
	assign bot_sel = sel[stack_pkg::DST_BOT];
	assign pk_sel = sel[stack_pkg::DST_PK];
	assign bot_pop = pop[stack_pkg::SRC_BOT];
	assign top_pop = pop[stack_pkg::SRC_TOP];
	assign bd_pop = pop[stack_pkg::SRC_BD];

endmodule

/* design/stack_core.sv */
module stack_core (
	input  logic                          osc,
	input  logic                          rst_n,
	// link to the board above
	input  logic [stack_pkg::FLIT_W-1:0]   top_in,
	input  logic                          top_in_valid,
	output logic                          top_in_ready,
	output logic [stack_pkg::FLIT_W-1:0]   top_out,
	output logic                          top_out_valid,
	input  logic                          top_out_ready,
	// link to the board below
	input  logic [stack_pkg::FLIT_W-1:0]   bot_in,
	input  logic                          bot_in_valid,
	output logic                          bot_in_ready,
	output logic [stack_pkg::FLIT_W-1:0]   bot_out,
	output logic                          bot_out_valid,
	input  logic                          bot_out_ready,
	// local chip
	output logic [stack_pkg::BD_OUT_W-1:0] bd_out_data,
	output logic                          bd_out_valid,
	input  logic                          bd_out_ready,
	input  logic [stack_pkg::BD_IN_W-1:0]  bd_in_data,
	input  logic                          bd_in_valid,
	output logic                          bd_in_ready
);

	stack_pkg::flit_u bot_head, top_head, bd_flit, pk_flit;
	logic bot_head_valid, top_head_valid, bd_flit_valid, bd_dir;
	logic bot_pop, top_pop, bd_pop;
	logic [1:0] top_sel, bot_sel, pk_sel;
	logic [2:0] move, dest_free;
	logic pk_valid, pk_ready;

	link_fifo i_bot_fifo (
		.osc(osc), .rst_n(rst_n),
		.in(bot_in), .in_valid(bot_in_valid), .pop(bot_pop),
		.in_ready(bot_in_ready), .head(bot_head), .head_valid(bot_head_valid)
	);

	link_fifo i_top_fifo (
		.osc(osc), .rst_n(rst_n),
		.in(top_in), .in_valid(top_in_valid), .pop(top_pop),
		.in_ready(top_in_ready), .head(top_head), .head_valid(top_head_valid)
	);

	route_ctrl i_route_ctrl (
		.osc(osc), .rst_n(rst_n),
		.bot_head(bot_head), .bot_head_valid(bot_head_valid),
		.top_head(top_head), .top_head_valid(top_head_valid),
		.bd_flit(bd_flit), .bd_flit_valid(bd_flit_valid), .bd_dir(bd_dir),
		.dest_free(dest_free),
		.bot_pop(bot_pop), .top_pop(top_pop), .bd_pop(bd_pop),
		.top_sel(top_sel), .bot_sel(bot_sel), .pk_sel(pk_sel), .move(move)
	);

	flit_switch i_flit_switch (
		.osc(osc), .rst_n(rst_n),
		.bot_head(bot_head), .top_head(top_head), .bd_flit(bd_flit),
		.top_sel(top_sel), .bot_sel(bot_sel), .pk_sel(pk_sel), .move(move),
		.top_out_ready(top_out_ready), .bot_out_ready(bot_out_ready), .pk_ready(pk_ready),
		.top_out(top_out), .top_out_valid(top_out_valid),
		.bot_out(bot_out), .bot_out_valid(bot_out_valid),
		.pk_flit(pk_flit), .pk_valid(pk_valid), .dest_free(dest_free)
	);

	bd_packer i_bd_packer (
		.osc(osc), .rst_n(rst_n),
		.pk_flit(pk_flit), .pk_valid(pk_valid), .bd_out_ready(bd_out_ready),
		.pk_ready(pk_ready), .bd_out_data(bd_out_data), .bd_out_valid(bd_out_valid)
	);

	bd_unpacker i_bd_unpacker (
		.osc(osc), .rst_n(rst_n),
		.bd_in_data(bd_in_data), .bd_in_valid(bd_in_valid), .bd_pop(bd_pop),
		.bd_in_ready(bd_in_ready), .bd_flit(bd_flit), .bd_flit_valid(bd_flit_valid),
		.bd_dir(bd_dir)
	);

endmodule

/* design/stack_pkg.sv */
package stack_pkg;

	// flit geometry
	localparam int FLIT_W = 11;  // tail + 10 bits
	localparam int HOP_W = 3;
	localparam int TAG_W = 7;
	localparam int PAY_W = 10;  // payload, also the low part of a header

	// chip side words
	localparam int BD_OUT_W = 21;  // last bit + two 10 bit fields
	localparam int BD_IN_W = 34;  // dir, hop, tag, spare, two payload halves
	localparam int BD_DIR_BIT = 33;  // 0 goes up, 1 goes down
	localparam int BD_HOP_LSB = 30;  // hop in 32:30
	localparam int BD_TAG_LSB = 23;  // tag in 29:23
	localparam int BD_LAST_BIT = 20;  // marks the final word of a packet

	localparam int FIFO_DEPTH = 4;  // per incoming link

	// sources feeding the switch
	localparam logic [1:0] SRC_BOT = 2'd0;
	localparam logic [1:0] SRC_TOP = 2'd1;
	localparam logic [1:0] SRC_BD = 2'd2;

	// destination slots, index into move / dest_free
	localparam int DST_TOP = 0;
	localparam int DST_BOT = 1;
	localparam int DST_PK = 2;

	localparam int NUM_PORTS = 3;  // three sources, three destinations

	// one flit word, read as header on the first flit and as payload after it
	typedef union packed {
		struct packed {
			logic tail;
			logic [HOP_W-1:0] hop;  // boards still to cross
			logic [TAG_W-1:0] tag;
		} hdr;
		struct packed {
			logic tail;
			logic [PAY_W-1:0] data;
		} pay;
	} flit_u;

endpackage

/* dv/stack_core_chk.sv */
module stack_core_chk (
	input logic                           osc,
	input logic                           rst_n,
	input logic [stack_pkg::FLIT_W-1:0]   top_out,
	input logic                           top_out_valid,
	input logic                           top_out_ready,
	input logic [stack_pkg::FLIT_W-1:0]   bot_out,
	input logic                           bot_out_valid,
	input logic                           bot_out_ready,
	input logic [stack_pkg::BD_OUT_W-1:0] bd_out_data,
	input logic                           bd_out_valid,
	input logic                           bd_out_ready,
	input logic                           top_in_ready,
	input logic                           bot_in_ready,
	input logic                           bd_in_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	// a stalled word stays offered and unchanged
	top_hold: assert property (@(posedge osc) disable iff (!rst_n)
		top_out_valid && !top_out_ready |=> top_out_valid && $stable(top_out))
		else $error("top_out dropped or changed while stalled");

	bot_hold: assert property (@(posedge osc) disable iff (!rst_n)
		bot_out_valid && !bot_out_ready |=> bot_out_valid && $stable(bot_out))
		else $error("bot_out dropped or changed while stalled");

	bd_hold: assert property (@(posedge osc) disable iff (!rst_n)
		bd_out_valid && !bd_out_ready |=> bd_out_valid && $stable(bd_out_data))
		else $error("bd_out_data dropped or changed while stalled");

	// leaving reset, nothing offered and every input open
	reset_idle: assert property (@(posedge osc) $rose(rst_n) |->
		!top_out_valid && !bot_out_valid && !bd_out_valid
		&& top_in_ready && bot_in_ready && bd_in_ready)
		else $error("core not idle when reset released");

endmodule

bind stack_core stack_core_chk i_chk (.*);

/* dv/stack_core_stim.txt */
// one record per line, first hex digit is the port code, the other nine the value
// 1 bot in, 2 top in, 3 chip in, 4/5 top out from bot/chip, 6/7 bot out from top/chip, 8/9 chip out from bot/top
1000000115
10000002A5
10000005C3
100000005A
1000000123
10000004AB
10000004C0
20000001BC
20000000F0
20000007FF
200000007F
2000000001
2000000200
2000000555
2000000433
3088DAF0D4
32770E845F
4000000095
40000002A5
40000005C3
4000000440
5000000111
50000002BC
50000004D4
600000013C
60000000F0
60000007FF
70000000EE
70000003A1
700000045F
8000016923
800012AC00
900001FC01
9000180155
900010CC00

/* dv/stack_core_tb.sv */
module stack_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int STIM_N = 64;  // stim array depth
	localparam int TIMEOUT = 5000;  // cycles allowed for all traffic

	logic osc;
	logic rst_n;
	logic [35:0] in_val [3];  // bot, top, chip
	logic in_vld [3];
	logic [2:0] in_rdy;
	logic [2:0] out_rdy;  // top, bot, chip
	logic [stack_pkg::FLIT_W-1:0] top_out;
	logic [stack_pkg::FLIT_W-1:0] bot_out;
	logic [stack_pkg::BD_OUT_W-1:0] bd_out_data;
	logic top_out_valid, bot_out_valid, bd_out_valid;

	logic [39:0] stim [STIM_N];  // code nibble over a 36 bit value
	logic [35:0] in_q [3][$];
	logic [35:0] exp_q [6][$];  // port * 2 + source slot
	int cur_src [3];  // queue owning the packet in flight, -1 between packets
	logic [31:0] lfsr;

	always #5 osc = ~osc;

	stack_core i_stack_core (
		.osc(osc), .rst_n(rst_n),
		.top_in(in_val[1][stack_pkg::FLIT_W-1:0]), .top_in_valid(in_vld[1]),
		.top_in_ready(in_rdy[1]),
		.top_out(top_out), .top_out_valid(top_out_valid), .top_out_ready(out_rdy[0]),
		.bot_in(in_val[0][stack_pkg::FLIT_W-1:0]), .bot_in_valid(in_vld[0]),
		.bot_in_ready(in_rdy[0]),
		.bot_out(bot_out), .bot_out_valid(bot_out_valid), .bot_out_ready(out_rdy[1]),
		.bd_out_data(bd_out_data), .bd_out_valid(bd_out_valid), .bd_out_ready(out_rdy[2]),
		.bd_in_data(in_val[2][stack_pkg::BD_IN_W-1:0]), .bd_in_valid(in_vld[2]),
		.bd_in_ready(in_rdy[2])
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic work_left();
		logic left;
		left = 1'b0;
		for (int p = 0; p < 3; p++)
			left = left | in_vld[p] | (in_q[p].size() > 0);
		for (int q = 0; q < 6; q++)
			left = left | (exp_q[q].size() > 0);  // still owed on some port
		return left;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [35:0] got, input logic [35:0] want);
		if (got !== want)
			stop_run($sformatf("Error: %s is %h, expected %h", name, got, want));
	endtask

	// a packet start picks the source whose next expected word it is
	task automatic take_output(input int port, input logic [35:0] got);
		int q;
		int end_bit;
		string name;
		q = port * 2;
		end_bit = (port == 2) ? stack_pkg::BD_LAST_BIT : stack_pkg::FLIT_W - 1;
		name = (port == 0) ? "top_out" : (port == 1) ? "bot_out" : "bd_out_data";
		if (cur_src[port] >= 0) begin
			q = cur_src[port];  // rest of the packet in flight
		end else if (exp_q[q].size() == 0 || exp_q[q][0] != got) begin
			if (exp_q[q + 1].size() > 0 && (exp_q[q + 1][0] == got || exp_q[q].size() == 0))
				q = q + 1;
		end
		if (exp_q[q].size() == 0)
			stop_run($sformatf("unexpected transfer on %s, nothing left to expect", name));
		compare(name, got, exp_q[q][0]);
		void'(exp_q[q].pop_front());
		cur_src[port] = got[end_bit] ? -1 : q;  // tail or last word ends the packet
	endtask

	// inputs move only just after the rise, so the fall sees settled handshakes
	always @(negedge osc) begin
		if (rst_n) begin
			if (top_out_valid && out_rdy[0])
				take_output(0, 36'(top_out));
			if (bot_out_valid && out_rdy[1])
				take_output(1, 36'(bot_out));
			if (bd_out_valid && out_rdy[2])
				take_output(2, 36'(bd_out_data));
		end
	end

	initial begin
		logic [39:0] rec;
		int code;
		int cycles;
		logic acc [3];
		osc = 1'b0;
		rst_n = 1'b0;
		out_rdy = '0;
		lfsr = 32'hfd302a3d;
		for (int p = 0; p < 3; p++) begin
			in_val[p] = '0;
			in_vld[p] = 1'b0;
			cur_src[p] = -1;
		end
		for (int i = 0; i < STIM_N; i++)
			stim[i] = '0;  // code 0 marks an unused slot
		$readmemh("dv/stack_core_stim.txt", stim);
		for (int i = 0; i < STIM_N; i++) begin
			rec = stim[i];
			code = int'(rec[39:36]);
			if (code >= 1 && code <= 3)
				in_q[code - 1].push_back(rec[35:0]);
			else if (code >= 4 && code <= 9)
				exp_q[code - 4].push_back(rec[35:0]);
			else if (code != 0)
				stop_run($sformatf("stim file holds unknown port code %0d", code));
		end

		repeat (5) @(posedge osc);
		#1 rst_n = 1'b1;

		cycles = 0;
		while (work_left()) begin
			@(negedge osc);
			for (int p = 0; p < 3; p++)
				acc[p] = in_vld[p] && in_rdy[p];  // taken at the coming rise
			@(posedge osc);
			#1;
			for (int p = 0; p < 3; p++) begin
				if (acc[p])
					in_vld[p] = 1'b0;
				if (!in_vld[p] && in_q[p].size() > 0) begin
					if (!lfsr_bit()) begin  // a one bit idles this cycle
						in_val[p] = in_q[p].pop_front();
						in_vld[p] = 1'b1;
					end
				end
			end
			for (int p = 0; p < 3; p++)
				out_rdy[p] = lfsr_bit();  // back-pressure per cycle
			cycles++;
			if (cycles > TIMEOUT)
				stop_run("timeout, traffic did not drain through the core");
		end

		out_rdy = '1;
		repeat (10) @(posedge osc);  // room for any stray output
		$display("Test OK");
		$finish;
	end

endmodule

/* flist.f */
design/stack_pkg.sv
design/link_fifo.sv
design/route_ctrl.sv
design/flit_switch.sv
design/bd_packer.sv
design/bd_unpacker.sv
design/stack_core.sv
dv/stack_core_chk.sv
dv/stack_core_tb.sv
